/* source/ntt_pkg.sv */
// ------------------------------
// NTT arithmetic definitions
//   modulus and Montgomery constants
//   coefficient and index types
//   forward twiddle table
//   engine state encoding
// ------------------------------
`default_nettype none

package ntt_pkg;

    // ------------------------------
    // block geometry
    // ------------------------------
    localparam int N_COEFF          = 128;
    localparam int LOG_N            = 7;
    localparam int NIBBLES_PER_WORD = 8;
    localparam int WORDS_PER_BLOCK  = 16;

    // residues live in [0, q)
    typedef logic [13:0]      coeff_t;
    typedef logic [LOG_N-1:0] coeff_idx_t;

    localparam coeff_t      Q         = 14'd12289;
    // -q^-1 mod 2^16, Montgomery radix R = 2^16
    localparam logic [15:0] Q_NEG_INV = 16'd12287;

    // ------------------------------
    // twiddles in Montgomery form
    // ------------------------------
    // index k = 2^stage + group, slot 0 never addressed
    localparam coeff_t TWIDDLES [N_COEFF] = '{
        0,     7888,  11060, 11208, 6960,  4342,  6275,  9759,
        1591,  6399,  9477,  5266,  586,   5825,  7538,  9710,
        1134,  6407,  1711,  965,   7099,  7674,  3743,  6442,
        10414, 8100,  1885,  1688,  1364,  10329, 10164, 9180,
        12210, 6240,  997,   117,   4783,  4407,  1549,  7072,
        2829,  6458,  4431,  8877,  7144,  2564,  5664,  4042,
        12189, 432,   10751, 1237,  7610,  1534,  3983,  7863,
        2181,  6308,  8720,  6570,  4843,  1690,  14,    3872,
        5569,  9368,  12163, 2019,  7543,  2315,  4673,  7340,
        1553,  1156,  8401,  11389, 1020,  2967,  10772, 7045,
        3316,  11236, 5285,  11578, 10637, 10086, 9493,  6180,
        9277,  6130,  3323,  883,   10469, 489,   1502,  2851,
        11061, 9729,  2742,  12241, 4970,  10481, 10078, 1195,
        730,   1762,  3854,  2030,  5892,  10922, 9020,  5274,
        9179,  3604,  3782,  10206, 3180,  3467,  4668,  2446,
        7613,  9386,  834,   7703,  6836,  3403,  5351,  12276
    };

    // engine FSM
    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_drain
    } engine_state_e;

endpackage

`default_nettype wire

/* source/wb_pkg.sv */
// ------------------------------
// bus and port structs
//   Wishbone request / response
//   output coefficient stream
//   row load and butterfly writes
// ------------------------------
`default_nettype none

package wb_pkg;
    import ntt_pkg::*;

    // host side, held until ack
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic ack;
    } wb_rsp_t;

    typedef struct packed {
        logic   valid;
        coeff_t data;
    } coeff_stream_t;

    // one word unpacked, lands at indices 8*row .. 8*row+7
    typedef struct packed {
        logic                              en;
        logic [3:0]                        row;
        coeff_t [NIBBLES_PER_WORD-1:0]     data;
    } row_wr_t;

    typedef struct packed {
        logic       we;
        coeff_idx_t addr_a;
        coeff_idx_t addr_b;
        coeff_t     data_a;
        coeff_t     data_b;
    } bfly_port_t;

endpackage

`default_nettype wire

/* source/coeff_loader.sv */
// ------------------------------
// Wishbone classic slave
//   unpacks 32-bit words into
//   rows of eight coefficients
//   and flags a complete block
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module coeff_loader import ntt_pkg::*, wb_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    input  logic    busy,
    output row_wr_t row_wr,
    output logic    block_ready
);

    logic                          ack;
    logic                          full;
    logic                          busy_q;
    logic [3:0]                    word_cnt;
    logic                          row_en;
    logic [3:0]                    row_idx;
    coeff_t [NIBBLES_PER_WORD-1:0] row_data;
    coeff_t [NIBBLES_PER_WORD-1:0] unpacked;
    logic                          take;
    logic                          take_wr;
    logic                          last_word;

    // no ack while the previous one is still on the bus
    assign take      = wb_req.cyc && wb_req.stb && !ack && !full && !busy;
    assign take_wr   = take && wb_req.we;
    assign last_word = (word_cnt == 4'(WORDS_PER_BLOCK - 1));

    // lowest nibble first, zero-extended
    always_comb begin
        for (int i = 0; i < NIBBLES_PER_WORD; i++) begin
            unpacked[i] = coeff_t'(wb_req.dat[4*i +: 4]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack         <= 1'b0;
            row_en      <= 1'b0;
            block_ready <= 1'b0;
            word_cnt    <= '0;
            busy_q      <= 1'b0;
            full        <= 1'b0;
        end else begin
            ack         <= take;
            row_en      <= take_wr;
            block_ready <= take_wr && last_word;
            busy_q      <= busy;
            if (take_wr) begin
                word_cnt <= word_cnt + 4'd1;
            end
            // hold off the next block until the engine has let go
            if (take_wr && last_word) begin
                full <= 1'b1;
            end else if (busy_q && !busy) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_wr) begin
            row_idx  <= word_cnt;
            row_data <= unpacked;
        end
    end

    assign wb_rsp = '{ack: ack};
    assign row_wr = '{en: row_en, row: row_idx, data: row_data};

endmodule

`default_nettype wire

/* source/coeff_ram.sv */
// ------------------------------
// coefficient register file
//   row load port
//   butterfly write pair
//   two async read ports
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module coeff_ram import ntt_pkg::*, wb_pkg::*; (
    input  logic       clk,
    input  row_wr_t    row_wr,
    input  bfly_port_t bfly,
    input  coeff_idx_t rd_addr_a,
    input  coeff_idx_t rd_addr_b,
    output coeff_t     rd_data_a,
    output coeff_t     rd_data_b
);

    // whole block, transformed in place
    coeff_t mem [N_COEFF];

    // ------------------------------
    // write side
    // ------------------------------
    // loader only writes while the engine is idle,
    // so the two sources never collide
    always_ff @(posedge clk) begin
        if (row_wr.en) begin
            for (int i = 0; i < NIBBLES_PER_WORD; i++) begin
                mem[{row_wr.row, i[2:0]}] <= row_wr.data[i];
            end
        end else if (bfly.we) begin
            mem[bfly.addr_a] <= bfly.data_a;
            mem[bfly.addr_b] <= bfly.data_b;
        end
    end

    // ------------------------------
    // read side
    // ------------------------------
    // combinational, butterfly sees its operands in the same cycle
    assign rd_data_a = mem[rd_addr_a];
    assign rd_data_b = mem[rd_addr_b];

endmodule

`default_nettype wire

/* source/mont_butterfly.sv */
// ------------------------------
// Cooley-Tukey butterfly
//   Montgomery multiply by twiddle
//   modular add and subtract
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module mont_butterfly import ntt_pkg::*; (
    input  coeff_t a,
    input  coeff_t b,
    input  coeff_t twiddle,
    output coeff_t sum,
    output coeff_t diff
);

    logic [27:0] prod;
    logic [15:0] m;
    logic [29:0] red;
    logic [13:0] z;
    coeff_t      t;
    logic [14:0] s_raw;

    // t = b * twiddle * 2^-16 mod q
    assign prod = 28'(b) * 28'(twiddle);
    assign m    = prod[15:0] * Q_NEG_INV;
    // low 16 bits cancel, z stays below 2q
    assign red  = 30'(prod) + 30'(m) * 30'(Q);
    assign z    = red[29:16];
    assign t    = (z >= Q) ? z - Q : z;

    assign s_raw = {1'b0, a} + {1'b0, t};
    assign sum   = (s_raw >= 15'(Q)) ? 14'(s_raw - 15'(Q)) : s_raw[13:0];
    // wraps mod 2^14 on the way, final value fits
    assign diff  = (a >= t) ? a - t : a + Q - t;

endmodule

`default_nettype wire

/* source/ntt_engine.sv */
// ------------------------------
// NTT engine
//   stage / group / offset sequencer
//   twiddle lookup, one butterfly per cycle
//   output stream with back-pressure
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module ntt_engine import ntt_pkg::*, wb_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          block_ready,
    output logic          busy,
    output coeff_idx_t    rd_addr_a,
    output coeff_idx_t    rd_addr_b,
    input  coeff_t        rd_data_a,
    input  coeff_t        rd_data_b,
    output bfly_port_t    bfly,
    output coeff_stream_t out_stream,
    input  logic          out_ready
);

    engine_state_e state;

    // half_len 64 -> 1, tw_base counts groups per stage (1 -> 64)
    logic [6:0] half_len;
    logic [6:0] tw_base;
    logic [5:0] grp;
    logic [5:0] off;
    coeff_idx_t j_base;
    coeff_idx_t out_idx;

    coeff_idx_t addr_a;
    coeff_idx_t addr_b;
    coeff_idx_t tw_idx;
    coeff_t     twiddle;
    coeff_t     bf_sum;
    coeff_t     bf_diff;
    logic       last_off;
    logic       last_grp;
    logic       last_stage;

    // ------------------------------
    // butterfly addressing
    // ------------------------------
    assign addr_a     = j_base + coeff_idx_t'(off);
    assign addr_b     = addr_a + half_len;
    assign tw_idx     = tw_base + coeff_idx_t'(grp);
    assign twiddle    = TWIDDLES[tw_idx];
    assign last_off   = (off == 6'(half_len - 7'd1));
    assign last_grp   = (grp == 6'(tw_base - 7'd1));
    assign last_stage = (half_len == 7'd1);

    mont_butterfly u_bfly (
        .a       (rd_data_a),
        .b       (rd_data_b),
        .twiddle (twiddle),
        .sum     (bf_sum),
        .diff    (bf_diff)
    );

    // port a doubles as the output read during drain
    assign rd_addr_a = (state == st_drain) ? out_idx : addr_a;
    assign rd_addr_b = addr_b;

    assign bfly = '{
        we:     (state == st_compute),
        addr_a: addr_a,
        addr_b: addr_b,
        data_a: bf_sum,
        data_b: bf_diff
    };

    // RAM is frozen in drain, so data holds while ready is low
    assign out_stream = '{valid: (state == st_drain), data: rd_data_a};
    assign busy       = (state != st_idle);

    // ------------------------------
    // sequencer
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            half_len <= 7'(N_COEFF / 2);
            tw_base  <= 7'd1;
            grp      <= '0;
            off      <= '0;
            j_base   <= '0;
            out_idx  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    half_len <= 7'(N_COEFF / 2);
                    tw_base  <= 7'd1;
                    grp      <= '0;
                    off      <= '0;
                    j_base   <= '0;
                    out_idx  <= '0;
                    if (block_ready) begin
                        state <= st_compute;
                    end
                end
                st_compute: begin
                    if (!last_off) begin
                        off <= off + 6'd1;
                    end else begin
                        off <= '0;
                        if (!last_grp) begin
                            grp    <= grp + 6'd1;
                            j_base <= j_base + (half_len << 1);
                        end else begin
                            // next stage: half the span, twice the groups
                            grp      <= '0;
                            j_base   <= '0;
                            half_len <= half_len >> 1;
                            tw_base  <= tw_base << 1;
                            if (last_stage) begin
                                state <= st_drain;
                            end
                        end
                    end
                end
                st_drain: begin
                    if (out_ready) begin
                        out_idx <= out_idx + 7'd1;
                        if (out_idx == 7'(N_COEFF - 1)) begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/ntt_top.sv */
// ------------------------------
// NTT top level
//   Wishbone loader, coefficient
//   RAM and transform engine
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module ntt_top import ntt_pkg::*, wb_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  wb_req_t       wb_req,
    output wb_rsp_t       wb_rsp,
    output coeff_stream_t out_stream,
    input  logic          out_ready
);

    logic       busy;
    logic       block_ready;
    row_wr_t    row_wr;
    bfly_port_t bfly;
    coeff_idx_t rd_addr_a;
    coeff_idx_t rd_addr_b;
    coeff_t     rd_data_a;
    coeff_t     rd_data_b;

    coeff_loader u_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .busy        (busy),
        .row_wr      (row_wr),
        .block_ready (block_ready)
    );

    coeff_ram u_ram (
        .clk       (clk),
        .row_wr    (row_wr),
        .bfly      (bfly),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    ntt_engine u_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .block_ready (block_ready),
        .busy        (busy),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .bfly        (bfly),
        .out_stream  (out_stream),
        .out_ready   (out_ready)
    );

endmodule

`default_nettype wire

/* tb/ntt_assertions.sv */
// ------------------------------
// bound protocol checks on ntt_top
//   Wishbone ack after a strobe
//   output data range
//   stream stable under back-pressure
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module ntt_assertions import ntt_pkg::*, wb_pkg::*; (
    input wire logic          clk,
    input wire logic          rst_n,
    input wire wb_req_t       wb_req,
    input wire wb_rsp_t       wb_rsp,
    input wire coeff_stream_t out_stream,
    input wire logic          out_ready
);

    // ack only answers a strobe seen one cycle earlier
    ack_follows_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack raised without a strobe in the previous cycle");

    // residues stay reduced
    data_below_q: assert property (@(posedge clk) disable iff (!rst_n)
        out_stream.valid |-> (out_stream.data < Q))
        else $error("output coefficient not reduced below the modulus");

    // stalled word must not change
    stable_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (out_stream.valid && !out_ready) |=> (out_stream.valid && $stable(out_stream.data)))
        else $error("output stream changed while ready was low");

endmodule

bind ntt_top ntt_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .out_stream (out_stream),
    .out_ready  (out_ready)
);

`default_nettype wire

/* tb/ntt_tb.sv */
// ------------------------------
// NTT testbench
//   clock, reset, Wishbone driver
//   Galois LFSR stimulus
//   reference transform, output checker
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module ntt_tb import ntt_pkg::*, wb_pkg::*;;

    localparam int          DRIVE_DLY   = 10;
    localparam int          ACK_TIMEOUT = 2000;
    localparam int          OUT_TIMEOUT = 4000;
    localparam int          QI          = int'(Q);
    localparam int          INV2        = (QI + 1) / 2;
    localparam logic [31:0] LFSR_SEED   = 32'h7a02_d133;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    logic          clk;
    logic          rst_n;
    wb_req_t       wb_req;
    wb_rsp_t       wb_rsp;
    coeff_stream_t out_stream;
    logic          out_ready;

    coeff_t      stim [N_COEFF];
    coeff_t      exp_blk [N_COEFF];
    logic [31:0] lfsr_data;
    logic [31:0] lfsr_rdy;
    bit          random_ready;
    int          rx_total;
    int          rx_limit;
    int          ack_total;
    int          err_mismatch;
    int          err_other;

    ntt_top u_ntt_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .out_stream (out_stream),
        .out_ready  (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // random numbers
    // ------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            lfsr_data = lfsr_next(lfsr_data);
            v = (v << 1) | int'(lfsr_data[0]);
        end
        return v;
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    // z * b * 2^-16 mod q, by halving sixteen times
    function automatic int mont_ref(input int z, input int b);
        longint p;
        int     i;
        p = (longint'(z) * longint'(b)) % longint'(QI);
        for (i = 0; i < 16; i++) begin
            p = (p * longint'(INV2)) % longint'(QI);
        end
        return int'(p);
    endfunction

    function automatic void ref_transform();
        int a [N_COEFF];
        int k;
        int len;
        int start;
        int j;
        int z;
        int t;
        for (j = 0; j < N_COEFF; j++) begin
            a[j] = int'(stim[j]);
        end
        k = 1;
        for (len = N_COEFF / 2; len >= 1; len = len / 2) begin
            for (start = 0; start < N_COEFF; start += 2 * len) begin
                z = int'(TWIDDLES[k]);
                k++;
                for (j = start; j < start + len; j++) begin
                    t = mont_ref(z, a[j + len]);
                    a[j + len] = (a[j] - t + QI) % QI;
                    a[j]       = (a[j] + t) % QI;
                end
            end
        end
        for (j = 0; j < N_COEFF; j++) begin
            exp_blk[j] = coeff_t'(a[j]);
        end
    endfunction

    // ------------------------------
    // drivers
    // ------------------------------
    task automatic abort_run(input string what);
        err_other++;
        $display("ERROR at %0t: %s", $time, what);
        $display("errors: %0d mismatches, %0d other", err_mismatch, err_other);
        $display("test failed");
        $finish;
    endtask

    // called at posedge + DRIVE_DLY, returns at the same phase
    task automatic wb_write(input logic [31:0] w);
        int cnt;
        bit got;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, dat: w};
        cnt = 0;
        got = 1'b0;
        while (!got && cnt < ACK_TIMEOUT) begin
            @(negedge clk);
            if (wb_rsp.ack) begin
                got = 1'b1;
            end else begin
                cnt++;
            end
        end
        if (!got) begin
            abort_run("no Wishbone ack for a write within the timeout");
        end else begin
            @(posedge clk);
            #DRIVE_DLY;
            wb_req = '0;
        end
    endtask

    task automatic load_block(input bit gaps);
        logic [31:0] w;
        int          wi;
        int          i;
        int          g;
        for (wi = 0; wi < WORDS_PER_BLOCK; wi++) begin
            for (i = 0; i < NIBBLES_PER_WORD; i++) begin
                w[4*i +: 4] = stim[NIBBLES_PER_WORD * wi + i][3:0];
            end
            wb_write(w);
            if (gaps) begin
                g = take_bits(2);
                repeat (g) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                end
            end
        end
    endtask

    task automatic wait_outputs(input int target);
        int cnt;
        cnt = 0;
        while (rx_total < target && cnt < OUT_TIMEOUT) begin
            @(posedge clk);
            cnt++;
        end
        if (rx_total < target) begin
            abort_run("output stream stopped before the block was complete");
        end else begin
            #DRIVE_DLY;
        end
    endtask

    task automatic run_block(input bit gaps);
        load_block(gaps);
        ref_transform();
        rx_limit += N_COEFF;
        wait_outputs(rx_limit);
        // idle a while so a surplus word would show up
        repeat (8) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic fill_random();
        int i;
        for (i = 0; i < N_COEFF; i++) begin
            stim[i] = coeff_t'(take_bits(4));
        end
    endtask

    task automatic fill_const(input int v);
        int i;
        for (i = 0; i < N_COEFF; i++) begin
            stim[i] = coeff_t'(v);
        end
    endtask

    // ready driver, own LFSR stream
    initial begin
        out_ready = 1'b1;
        lfsr_rdy  = LFSR_SEED;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (random_ready) begin
                lfsr_rdy  = lfsr_next(lfsr_rdy);
                out_ready = lfsr_rdy[0];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // ------------------------------
    // comparing process
    // ------------------------------
    always @(negedge clk) begin
        if (rst_n && wb_rsp.ack) begin
            // a block only loads once every earlier output has left
            assert (rx_total == (ack_total / WORDS_PER_BLOCK) * N_COEFF) else begin
                err_other++;
                $display("ERROR at %0t: ack for word %0d while %0d outputs had left",
                         $time, ack_total, rx_total);
            end
            ack_total++;
        end
        if (rst_n && out_stream.valid && out_ready) begin
            if (rx_total >= rx_limit) begin
                err_other++;
                $display("ERROR at %0t: output word arrived with no block pending", $time);
            end else begin
                assert (out_stream.data == exp_blk[rx_total % N_COEFF]) else begin
                    err_mismatch++;
                    $display("MISMATCH time %0t out_stream.data[%0d] got %0d expected %0d",
                             $time, rx_total % N_COEFF, out_stream.data,
                             exp_blk[rx_total % N_COEFF]);
                end
            end
            rx_total++;
        end
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        rst_n        = 1'b0;
        wb_req       = '0;
        lfsr_data    = LFSR_SEED;
        random_ready = 1'b0;
        rx_total     = 0;
        rx_limit     = 0;
        ack_total    = 0;
        err_mismatch = 0;
        err_other    = 0;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // quiet outputs before any strobe
        repeat (4) begin
            @(negedge clk);
            assert (!wb_rsp.ack && !out_stream.valid) else begin
                err_other++;
                $display("ERROR at %0t: ack or out valid high before the first strobe", $time);
            end
        end
        @(posedge clk);
        #DRIVE_DLY;

        // random block, ready held high
        fill_random();
        run_block(1'b0);

        // gaps between strobes, random back-pressure
        fill_random();
        random_ready = 1'b1;
        run_block(1'b1);
        random_ready = 1'b0;

        fill_const(0);
        run_block(1'b0);
        fill_const(15);
        run_block(1'b0);

        // second block strobed while the first is in flight
        fill_random();
        load_block(1'b0);
        ref_transform();
        rx_limit += N_COEFF;
        fill_random();
        load_block(1'b0);
        ref_transform();
        rx_limit += N_COEFF;
        wait_outputs(rx_limit);
        repeat (8) @(posedge clk);

        $display("errors: %0d mismatches, %0d other", err_mismatch, err_other);
        if (err_mismatch + err_other == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
source/ntt_pkg.sv
source/wb_pkg.sv
source/coeff_loader.sv
source/coeff_ram.sv
source/mont_butterfly.sv
source/ntt_engine.sv
source/ntt_top.sv
tb/ntt_assertions.sv
tb/ntt_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the NTT testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f compile.f \
    --top-module ntt_tb \
    -o ntt_sim

./obj_dir/ntt_sim 2>&1 | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "run.sh: simulation ok"
    exit 0
else
    echo "run.sh: simulation reported failure"
    exit 1
fi
